// File: vlog.f
common/wfg_stim_sine_pkg.sv
source/wfg_stim_sine_wb_regs.sv
source/sine_ctrl_fsm.sv
source/cordic_iter_counter.sv
cordic/cordic_rotator.sv
source/sine_sample_scaler.sv
source/wfg_stim_sine_top.sv
tb/wfg_stim_sine_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = wfg_stim_sine_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
PASS_MSG = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only if the pass message shows up as a line of its own
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/wfg_stim_sine_tb.sv
// directed testbench for the sine stimulus generator
// programs the registers over wishbone and checks samples against a real sine model
`timescale 1ns/10ps
module wfg_stim_sine_tb import wfg_stim_sine_pkg::*; ();

    localparam int LATENCY = 18;
    localparam int TOL     = 4;
    // 6 tests x 200 samples x 19 clocks x 20 ns, plus margin
    localparam int WATCHDOG_NS = 6 * 200 * 19 * 20 + 100000;
    localparam real PI = 3.14159265358979;

    logic        wb_clk_i;
    logic        wb_rst_i;
    logic        wbs_stb_i;
    logic        wbs_cyc_i;
    logic        wbs_we_i;
    logic [3:0]  wbs_sel_i;
    logic [31:0] wbs_dat_i;
    logic [31:0] wbs_adr_i;
    logic        wbs_ack_o;
    logic [31:0] wbs_dat_o;
    logic        stim_req_i;
    logic [15:0] sample_o;
    logic        sample_valid_o;
    logic        busy_o;

    int          errors;
    int          checks;
    int          test_start_errors;
    // shadow of the generator state
    logic [15:0] model_phase;
    logic [15:0] cur_inc;
    logic [15:0] cur_gain;
    logic [15:0] cur_offset;

    wfg_stim_sine_top u_wfg_stim_sine_top (
        .wb_clk_i       (wb_clk_i),
        .wb_rst_i       (wb_rst_i),
        .wbs_stb_i      (wbs_stb_i),
        .wbs_cyc_i      (wbs_cyc_i),
        .wbs_we_i       (wbs_we_i),
        .wbs_sel_i      (wbs_sel_i),
        .wbs_dat_i      (wbs_dat_i),
        .wbs_adr_i      (wbs_adr_i),
        .wbs_ack_o      (wbs_ack_o),
        .wbs_dat_o      (wbs_dat_o),
        .stim_req_i     (stim_req_i),
        .sample_o       (sample_o),
        .sample_valid_o (sample_valid_o),
        .busy_o         (busy_o)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #10 wb_clk_i = ~wb_clk_i;
    end

    task automatic show_mismatch(input string name, input int got, input int exp);
        errors++;
        $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic close_test(input string name);
        $display("test %s finished with %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    // wait for ack at negedges, then drop the cycle and expect ack gone
    task automatic finish_bus_cycle(output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(negedge wb_clk_i);
        while (!wbs_ack_o && waited < 10) begin
            waited++;
            @(negedge wb_clk_i);
        end
        checks++;
        if (!wbs_ack_o) begin
            note_failure("wishbone access got no ack");
        end
        rdata = wbs_dat_o;
        @(posedge wb_clk_i);
        wbs_cyc_i <= 1'b0;
        wbs_stb_i <= 1'b0;
        wbs_we_i  <= 1'b0;
        @(negedge wb_clk_i);
        checks++;
        if (wbs_ack_o) begin
            note_failure("ack stayed high for a second cycle");
        end
    endtask

    task automatic wb_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        @(posedge wb_clk_i);
        wbs_cyc_i <= 1'b1;
        wbs_stb_i <= 1'b1;
        wbs_we_i  <= 1'b1;
        wbs_adr_i <= {20'h0, addr};
        wbs_dat_i <= data;
        finish_bus_cycle(unused);
    endtask

    task automatic wb_read(input logic [11:0] addr, output logic [31:0] data);
        @(posedge wb_clk_i);
        wbs_cyc_i <= 1'b1;
        wbs_stb_i <= 1'b1;
        wbs_we_i  <= 1'b0;
        wbs_adr_i <= {20'h0, addr};
        finish_bus_cycle(data);
    endtask

    task automatic read_and_check(input string name, input logic [11:0] addr,
                                  input logic [31:0] exp);
        logic [31:0] got;
        wb_read(addr, got);
        checks++;
        if (got !== exp) begin
            show_mismatch(name, int'(got), int'(exp));
        end
    endtask

    task automatic set_scaling(input logic [15:0] inc, input logic [15:0] gain,
                               input logic [15:0] offset);
        wb_write(ADDR_INC, {16'h0, inc});
        wb_write(ADDR_GAIN, {16'h0, gain});
        wb_write(ADDR_OFFSET, {16'h0, offset});
        cur_inc    = inc;
        cur_gain   = gain;
        cur_offset = offset;
    endtask

    // sin scaled to 32767, times Q2.14 gain, floored, plus signed offset
    function automatic int model_unclamped(input logic [15:0] phase,
                                           input logic [15:0] gain,
                                           input logic [15:0] offset);
        real ph_r;
        real gain_r;
        real off_r;
        real sin_q;
        int  off_i;
        off_i  = int'($signed(offset));
        ph_r   = phase;
        gain_r = gain;
        off_r  = off_i;
        sin_q  = $sin(2.0 * PI * ph_r / 65536.0) * 32767.0;
        return $rtoi($floor(sin_q * gain_r / 16384.0) + off_r);
    endfunction

    // one strobe, then count clocks until sample_valid_o
    task automatic request_sample(output int value, output logic got_one);
        int lat;
        @(posedge wb_clk_i);
        stim_req_i <= 1'b1;
        @(posedge wb_clk_i);
        stim_req_i <= 1'b0;
        lat     = 0;
        got_one = 1'b0;
        while (!got_one && lat < 60) begin
            @(negedge wb_clk_i);
            if (sample_valid_o) begin
                got_one = 1'b1;
            end else begin
                lat++;
            end
        end
        checks++;
        if (!got_one) begin
            note_failure("no sample_valid_o after an accepted request");
        end else if (lat != LATENCY) begin
            show_mismatch("sample latency", lat, LATENCY);
        end
        value = int'($signed(sample_o));
    endtask

    task automatic sample_and_compare();
        int   got;
        int   raw;
        int   exp;
        int   tol;
        logic ok;
        request_sample(got, ok);
        raw = model_unclamped(model_phase, cur_gain, cur_offset);
        exp = (raw > 32767) ? 32767 : ((raw < -32768) ? -32768 : raw);
        // sine error grows with gain
        tol = (cur_gain > 16'h4000) ? 2 * TOL : TOL;
        // deep in saturation the output sits on the rail
        if (raw > 32767 + 4 * TOL || raw < -32768 - 4 * TOL) begin
            tol = 0;
        end
        checks++;
        if (ok && (got > exp + tol || got < exp - tol)) begin
            show_mismatch("sample_o", got, exp);
        end
        model_phase = model_phase + cur_inc;
    endtask

    task automatic check_reset_state();
        checks++;
        if (wbs_ack_o || sample_valid_o || busy_o) begin
            note_failure("ack, valid or busy high after reset");
        end
        read_and_check("wbs_dat_o gain", ADDR_GAIN, 32'h0000_4000);
        read_and_check("wbs_dat_o inc", ADDR_INC, 32'h0000_1000);
        read_and_check("wbs_dat_o offset", ADDR_OFFSET, 32'h0000_0000);
        read_and_check("wbs_dat_o ctrl", ADDR_CTRL, 32'h0000_0000);
        read_and_check("wbs_dat_o id", ADDR_ID, 32'h0000_0101);
        read_and_check("wbs_dat_o reginfo", ADDR_REGINFO, 32'd220223);
        // identification is read only
        wb_write(ADDR_ID, 32'hFFFF_FFFF);
        read_and_check("wbs_dat_o id after write", ADDR_ID, 32'h0000_0101);
        close_test("reset state");
    endtask

    task automatic check_register_access();
        logic seen;
        set_scaling(16'h1234, 16'h5678, 16'h9ABC);
        read_and_check("wbs_dat_o inc", ADDR_INC, 32'h0000_1234);
        read_and_check("wbs_dat_o gain", ADDR_GAIN, 32'h0000_5678);
        read_and_check("wbs_dat_o offset", ADDR_OFFSET, 32'h0000_9ABC);
        wb_write(ADDR_CTRL, 32'h1);
        read_and_check("wbs_dat_o ctrl", ADDR_CTRL, 32'h1);
        wb_write(ADDR_CTRL, 32'h0);
        read_and_check("wbs_dat_o ctrl", ADDR_CTRL, 32'h0);
        // strobe with the enable low
        @(posedge wb_clk_i);
        stim_req_i <= 1'b1;
        @(posedge wb_clk_i);
        stim_req_i <= 1'b0;
        seen = 1'b0;
        repeat (40) begin
            @(negedge wb_clk_i);
            if (sample_valid_o || busy_o) begin
                seen = 1'b1;
            end
        end
        checks++;
        if (seen) begin
            note_failure("request was taken while CTRL.EN was low");
        end
        close_test("register access");
    endtask

    task automatic run_default_sine();
        set_scaling(16'h1000, 16'h4000, 16'h0000);
        wb_write(ADDR_CTRL, 32'h1);
        model_phase = 16'h0000;
        repeat (16) sample_and_compare();
        close_test("default sine");
    endtask

    task automatic run_random_increments();
        logic [15:0] inc;
        repeat (4) begin
            inc = 16'($urandom);
            wb_write(ADDR_INC, {16'h0, inc});
            cur_inc = inc;
            repeat (8) sample_and_compare();
        end
        close_test("random increments");
    endtask

    task automatic run_saturation();
        // restart the phase so the rails are hit on known samples
        wb_write(ADDR_CTRL, 32'h0);
        set_scaling(16'h1000, 16'h8000, 16'h6000);
        wb_write(ADDR_CTRL, 32'h1);
        model_phase = 16'h0000;
        repeat (16) sample_and_compare();
        // half gain, offset of -12000
        set_scaling(16'h0C00, 16'h2000, 16'hD120);
        repeat (16) sample_and_compare();
        close_test("gain and offset");
    endtask

    task automatic run_busy_and_restart();
        int pulses;
        set_scaling(16'h1000, 16'h4000, 16'h0000);
        repeat (3) sample_and_compare();
        // one accepted strobe, then more strobes while busy
        @(posedge wb_clk_i);
        stim_req_i <= 1'b1;
        @(posedge wb_clk_i);
        for (int i = 0; i < 14; i++) begin
            stim_req_i <= (i % 2 == 0);
            @(negedge wb_clk_i);
            checks++;
            if (!busy_o) begin
                note_failure("busy_o low while a sample was in flight");
            end
            @(posedge wb_clk_i);
        end
        stim_req_i <= 1'b0;
        pulses = 0;
        repeat (50) begin
            @(negedge wb_clk_i);
            if (sample_valid_o) begin
                pulses++;
            end
        end
        checks++;
        if (pulses != 1) begin
            show_mismatch("sample_valid_o pulses", pulses, 1);
        end
        model_phase = model_phase + cur_inc;
        sample_and_compare();
        // enable toggle puts the phase back to zero
        wb_write(ADDR_CTRL, 32'h0);
        wb_write(ADDR_CTRL, 32'h1);
        model_phase = 16'h0000;
        repeat (3) sample_and_compare();
        close_test("busy and restart");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Checks failed");
        $finish;
    end

    initial begin
        void'($urandom(58212));
        errors            = 0;
        checks            = 0;
        test_start_errors = 0;
        model_phase       = 16'h0000;
        cur_inc           = 16'h1000;
        cur_gain          = 16'h4000;
        cur_offset        = 16'h0000;
        wb_rst_i          = 1'b1;
        wbs_stb_i         = 1'b0;
        wbs_cyc_i         = 1'b0;
        wbs_we_i          = 1'b0;
        wbs_sel_i         = 4'hF;
        wbs_dat_i         = 32'h0;
        wbs_adr_i         = 32'h0;
        stim_req_i        = 1'b0;
        repeat (2) @(posedge wb_clk_i);
        wb_rst_i <= 1'b0;
        check_reset_state();
        check_register_access();
        run_default_sine();
        run_random_increments();
        run_saturation();
        run_busy_and_restart();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: source/wfg_stim_sine_top.sv
// sine stimulus generator top, wishbone control plus sample strobe
// each accepted stim_req_i gives one sample 18 clocks later
`timescale 1ns/10ps
`default_nettype none
module wfg_stim_sine_top import wfg_stim_sine_pkg::*; (
    input  logic        wb_clk_i,
    input  logic        wb_rst_i,
    input  logic        wbs_stb_i,
    input  logic        wbs_cyc_i,
    input  logic        wbs_we_i,
    input  logic [3:0]  wbs_sel_i,
    input  logic [31:0] wbs_dat_i,
    input  logic [31:0] wbs_adr_i,
    output logic        wbs_ack_o,
    output logic [31:0] wbs_dat_o,
    input  logic        stim_req_i,
    output logic [15:0] sample_o,
    output logic        sample_valid_o,
    output logic        busy_o
);

    // register outputs
    logic               ctrl_en;
    logic [15:0]        inc_val;
    logic [15:0]        gain_val;
    logic [15:0]        offset_val;
    // controller strobes
    logic               rot_load;
    logic               rot_step;
    logic               cnt_clear;
    logic               scale_capture;
    logic [15:0]        phase;
    // cordic
    logic [ITER_W-1:0]  iter;
    logic               iter_last;
    logic signed [15:0] sin_q;

    wfg_stim_sine_wb_regs u_wb_regs (
        .wb_clk_i     (wb_clk_i),
        .wb_rst_i     (wb_rst_i),
        .wbs_stb_i    (wbs_stb_i),
        .wbs_cyc_i    (wbs_cyc_i),
        .wbs_we_i     (wbs_we_i),
        .wbs_sel_i    (wbs_sel_i),
        .wbs_dat_i    (wbs_dat_i),
        .wbs_adr_i    (wbs_adr_i),
        .wbs_ack_o    (wbs_ack_o),
        .wbs_dat_o    (wbs_dat_o),
        .ctrl_en_o    (ctrl_en),
        .inc_val_o    (inc_val),
        .gain_val_o   (gain_val),
        .offset_val_o (offset_val)
    );

    sine_ctrl_fsm u_ctrl_fsm (
        .wb_clk_i        (wb_clk_i),
        .wb_rst_i        (wb_rst_i),
        .ctrl_en_i       (ctrl_en),
        .inc_val_i       (inc_val),
        .stim_req_i      (stim_req_i),
        .iter_last_i     (iter_last),
        .busy_o          (busy_o),
        .rot_load_o      (rot_load),
        .rot_step_o      (rot_step),
        .cnt_clear_o     (cnt_clear),
        .scale_capture_o (scale_capture),
        .phase_o         (phase)
    );

    // counter steps together with the rotator
    cordic_iter_counter u_iter_counter (
        .wb_clk_i    (wb_clk_i),
        .wb_rst_i    (wb_rst_i),
        .cnt_clear_i (cnt_clear),
        .cnt_en_i    (rot_step),
        .iter_o      (iter),
        .iter_last_o (iter_last)
    );

    cordic_rotator u_rotator (
        .wb_clk_i   (wb_clk_i),
        .wb_rst_i   (wb_rst_i),
        .rot_load_i (rot_load),
        .rot_step_i (rot_step),
        .phase_i    (phase),
        .iter_i     (iter),
        .sin_q_o    (sin_q)
    );

    sine_sample_scaler u_scaler (
        .wb_clk_i        (wb_clk_i),
        .wb_rst_i        (wb_rst_i),
        .scale_capture_i (scale_capture),
        .sin_q_i         (sin_q),
        .gain_val_i      (gain_val),
        .offset_val_i    (offset_val),
        .sample_o        (sample_o),
        .sample_valid_o  (sample_valid_o)
    );

endmodule
`default_nettype wire

// File: source/sine_sample_scaler.sv
// gain, offset and saturation for one sine sample
// gain is unsigned Q2.14, offset is signed
`timescale 1ns/10ps
`default_nettype none
module sine_sample_scaler (
    input  logic               wb_clk_i,
    input  logic               wb_rst_i,
    input  logic               scale_capture_i,
    input  logic signed [15:0] sin_q_i,
    input  logic [15:0]        gain_val_i,
    input  logic [15:0]        offset_val_i,
    output logic [15:0]        sample_o,
    output logic               sample_valid_o
);

    logic signed [32:0] product;
    logic signed [32:0] sum;
    logic [15:0]        sat;

    // gain zero-extended so it stays positive
    assign product = 33'(sin_q_i) * 33'($signed({1'b0, gain_val_i}));
    assign sum     = (product >>> 14) + 33'($signed(offset_val_i));

    always_comb begin
        if (sum > 33'sd32767) begin
            sat = 16'h7FFF;
        end else if (sum < -33'sd32768) begin
            sat = 16'h8000;
        end else begin
            sat = sum[15:0];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (scale_capture_i) begin
            sample_o <= sat;
        end
    end

    // one pulse per capture
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            sample_valid_o <= 1'b0;
        end else begin
            sample_valid_o <= scale_capture_i;
        end
    end

    // no stream handshake so each sample shows once
    assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        sample_valid_o |=> !sample_valid_o);

endmodule
`default_nettype wire

// File: cordic/cordic_rotator.sv
// iterative cordic rotator, one micro-rotation per step
// folds the phase into +-90 degrees and returns sin scaled to 32767
`timescale 1ns/10ps
`default_nettype none
module cordic_rotator import wfg_stim_sine_pkg::*; (
    input  logic               wb_clk_i,
    input  logic               wb_rst_i,
    input  logic               rot_load_i,
    input  logic               rot_step_i,
    input  logic [15:0]        phase_i,
    input  logic [ITER_W-1:0]  iter_i,
    output logic signed [15:0] sin_q_o
);

    logic signed [CORDIC_W-1:0] x_q;
    logic signed [CORDIC_W-1:0] y_q;
    logic signed [CORDIC_W-1:0] z_q;
    logic                       neg_q;
    logic                       fold;
    logic [15:0]                folded;
    logic signed [CORDIC_W-1:0] z_init;
    logic signed [CORDIC_W-1:0] y_rnd;
    logic signed [CORDIC_W-1:0] sin_full;

    // quadrants 2 and 3 move by half a turn, sign flips back at the end
    assign fold   = phase_i[15] ^ phase_i[14];
    assign folded = fold ? (phase_i ^ 16'h8000) : phase_i;
    assign z_init = CORDIC_W'($signed(folded)) <<< CORDIC_Z_FRAC;

    // x, y, z datapath
    always_ff @(posedge wb_clk_i) begin
        if (rot_load_i) begin
            x_q <= CORDIC_K_INIT;
            y_q <= '0;
            z_q <= z_init;
        end else if (rot_step_i) begin
            // rotate toward z = 0
            if (!z_q[CORDIC_W-1]) begin
                x_q <= x_q - (y_q >>> iter_i);
                y_q <= y_q + (x_q >>> iter_i);
                z_q <= z_q - ATAN_TABLE[iter_i];
            end else begin
                x_q <= x_q + (y_q >>> iter_i);
                y_q <= y_q - (x_q >>> iter_i);
                z_q <= z_q + ATAN_TABLE[iter_i];
            end
        end
    end

    // negate flag for the folded quadrants
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            neg_q <= 1'b0;
        end else if (rot_load_i) begin
            neg_q <= fold;
        end
    end

    // drop fraction bits with rounding, undo the fold
    assign y_rnd    = (y_q + CORDIC_W'(1 <<< (CORDIC_XY_FRAC - 1))) >>> CORDIC_XY_FRAC;
    assign sin_full = neg_q ? -y_rnd : y_rnd;

    // clamp, since rounding can reach 32768
    always_ff @(posedge wb_clk_i) begin
        if (sin_full > CORDIC_W'(32767)) begin
            sin_q_o <= 16'sd32767;
        end else if (sin_full < -CORDIC_W'(32767)) begin
            sin_q_o <= -16'sd32767;
        end else begin
            sin_q_o <= sin_full[15:0];
        end
    end

endmodule
`default_nettype wire

// File: source/cordic_iter_counter.sv
// cordic iteration index that counts 0 to 15 and holds at the last one
`timescale 1ns/10ps
`default_nettype none
module cordic_iter_counter import wfg_stim_sine_pkg::*; (
    input  logic              wb_clk_i,
    input  logic              wb_rst_i,
    input  logic              cnt_clear_i,
    input  logic              cnt_en_i,
    output logic [ITER_W-1:0] iter_o,
    output logic              iter_last_o
);

    assign iter_last_o = (iter_o == ITER_W'(CORDIC_ITERS - 1));

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            iter_o <= '0;
        end else if (cnt_clear_i) begin
            iter_o <= '0;
        end else if (cnt_en_i && !iter_last_o) begin
            iter_o <= iter_o + ITER_W'(1);
        end
    end

    // the step taken at index 15 is the last one the controller asks for
    assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        (iter_last_o && cnt_en_i) |=> !cnt_en_i);

endmodule
`default_nettype wire

// File: source/sine_ctrl_fsm.sv
// sample controller, one sine sample per accepted request
// also holds the phase accumulator
`timescale 1ns/10ps
`default_nettype none
module sine_ctrl_fsm import wfg_stim_sine_pkg::*; (
    input  logic        wb_clk_i,
    input  logic        wb_rst_i,
    input  logic        ctrl_en_i,
    input  logic [15:0] inc_val_i,
    input  logic        stim_req_i,
    input  logic        iter_last_i,
    output logic        busy_o,
    output logic        rot_load_o,
    output logic        rot_step_o,
    output logic        cnt_clear_o,
    output logic        scale_capture_o,
    output logic [15:0] phase_o
);

    sine_state_e state_q;
    sine_state_e state_d;
    logic [15:0] acc_q;
    logic        accept;
    logic        scale_capture_q;

    // requests outside idle or while disabled are dropped
    assign accept = (state_q == S_IDLE) && ctrl_en_i && stim_req_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (accept) begin
                    state_d = S_ITERATE;
                end
            end
            S_ITERATE: begin
                // last step happens on this edge
                if (iter_last_i) begin
                    state_d = S_SCALE;
                end
            end
            S_SCALE: begin
                // one wait cycle for the rotator output register
                if (scale_capture_q) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state_q         <= S_IDLE;
            scale_capture_q <= 1'b0;
        end else begin
            state_q         <= state_d;
            scale_capture_q <= (state_q == S_SCALE) && !scale_capture_q;
        end
    end

    // phase accumulator, zero while disabled
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            acc_q <= '0;
        end else if (!ctrl_en_i) begin
            acc_q <= '0;
        end else if (accept) begin
            acc_q <= acc_q + inc_val_i;
        end
    end

    assign busy_o          = (state_q != S_IDLE);
    assign rot_load_o      = accept;
    assign cnt_clear_o     = accept;
    assign rot_step_o      = (state_q == S_ITERATE);
    assign scale_capture_o = scale_capture_q;
    // rotator samples the pre-increment value at the accept edge
    assign phase_o         = acc_q;

    // loads come from idle and never overlap a sample in flight
    assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        rot_load_o |-> (state_q == S_IDLE) ##1 !rot_load_o [*18]);

endmodule
`default_nettype wire

// File: source/wfg_stim_sine_wb_regs.sv
// wishbone register slave for the sine generator
// holds ctrl, inc, gain and offset, ID and REGINFO read as constants
`timescale 1ns/10ps
`default_nettype none
module wfg_stim_sine_wb_regs import wfg_stim_sine_pkg::*; (
    input  logic        wb_clk_i,
    input  logic        wb_rst_i,
    input  logic        wbs_stb_i,
    input  logic        wbs_cyc_i,
    input  logic        wbs_we_i,
    // byte lanes are not decoded, full words only
    input  logic [3:0]  wbs_sel_i,
    input  logic [31:0] wbs_dat_i,
    input  logic [31:0] wbs_adr_i,
    output logic        wbs_ack_o,
    output logic [31:0] wbs_dat_o,
    output logic        ctrl_en_o,
    output logic [15:0] inc_val_o,
    output logic [15:0] gain_val_o,
    output logic [15:0] offset_val_o
);

    logic        wb_active;
    logic        wb_write;
    logic [11:0] adr_low;
    logic [31:0] rd_data;

    // new access only while ack is low, so one ack per cycle
    assign wb_active = wbs_cyc_i && wbs_stb_i && !wbs_ack_o;
    assign wb_write  = wb_active && wbs_we_i;
    assign adr_low   = wbs_adr_i[11:0];

    // writable registers
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            ctrl_en_o    <= 1'b0;
            inc_val_o    <= RST_INC;
            gain_val_o   <= RST_GAIN;
            offset_val_o <= RST_OFFSET;
        end else if (wb_write) begin
            case (adr_low)
                ADDR_CTRL:   ctrl_en_o    <= wbs_dat_i[0];
                ADDR_INC:    inc_val_o    <= wbs_dat_i[15:0];
                ADDR_GAIN:   gain_val_o   <= wbs_dat_i[15:0];
                ADDR_OFFSET: offset_val_o <= wbs_dat_i[15:0];
                // ID, REGINFO and holes drop the write
                default: ;
            endcase
        end
    end

    // read mux, unmapped reads zero
    always_comb begin
        rd_data = '0;
        case (adr_low)
            ADDR_CTRL:    rd_data[0]    = ctrl_en_o;
            ADDR_INC:     rd_data[15:0] = inc_val_o;
            ADDR_GAIN:    rd_data[15:0] = gain_val_o;
            ADDR_OFFSET:  rd_data[15:0] = offset_val_o;
            ADDR_REGINFO: rd_data[19:0] = REGINFO_DATE;
            ADDR_ID:      rd_data[15:0] = {ID_VERSION, ID_PERIPHERAL_TYPE};
            default:      rd_data       = '0;
        endcase
    end

    // ack one clock after the access starts
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            wbs_ack_o <= 1'b0;
        end else begin
            wbs_ack_o <= wb_active;
        end
    end

    // read data latched with ack
    always_ff @(posedge wb_clk_i) begin
        if (wb_active) begin
            wbs_dat_o <= rd_data;
        end
    end

    // every access gets exactly one ack, then a gap
    assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        (wbs_cyc_i && wbs_stb_i && !wbs_ack_o) |=> (wbs_ack_o ##1 !wbs_ack_o));

endmodule
`default_nettype wire

// File: common/wfg_stim_sine_pkg.sv
// shared constants for the sine stimulus generator
// register map, reset values, CORDIC tables and controller states
package wfg_stim_sine_pkg;

    // register offsets, low 12 address bits only
    localparam logic [11:0] ADDR_CTRL    = 12'h010;
    localparam logic [11:0] ADDR_INC     = 12'h018;
    localparam logic [11:0] ADDR_GAIN    = 12'h01C;
    localparam logic [11:0] ADDR_OFFSET  = 12'h020;
    localparam logic [11:0] ADDR_REGINFO = 12'hFF8;
    localparam logic [11:0] ADDR_ID      = 12'hFFC;

    // reset values
    localparam logic [15:0] RST_GAIN   = 16'h4000;
    localparam logic [15:0] RST_INC    = 16'h1000;
    localparam logic [15:0] RST_OFFSET = 16'h0000;

    // read-only identification
    localparam logic [7:0]  ID_PERIPHERAL_TYPE = 8'h01;
    localparam logic [7:0]  ID_VERSION         = 8'h01;
    localparam logic [19:0] REGINFO_DATE       = 20'd220223;

    // cordic sizing
    localparam int CORDIC_ITERS = 16;
    localparam int ITER_W       = 4;
    localparam int CORDIC_W     = 20;
    // x/y carry 3 fraction bits, z carries 4 below the 16-bit phase
    localparam int CORDIC_XY_FRAC = 3;
    localparam int CORDIC_Z_FRAC  = 4;

    // 0.60725 * 32767 * 2^3, cancels the rotation gain
    localparam logic signed [CORDIC_W-1:0] CORDIC_K_INIT = 20'sd159182;

    // atan(2^-i), 2^20 units per full turn
    localparam logic signed [CORDIC_W-1:0] ATAN_TABLE [0:CORDIC_ITERS-1] = '{
        20'sd131072, 20'sd77376, 20'sd40884, 20'sd20753,
        20'sd10417,  20'sd5213,  20'sd2607,  20'sd1304,
        20'sd652,    20'sd326,   20'sd163,   20'sd81,
        20'sd41,     20'sd20,    20'sd10,    20'sd5
    };

    // sample controller
    typedef enum logic [1:0] {
        S_IDLE,
        S_ITERATE,
        S_SCALE
    } sine_state_e;

endpackage
